/* verilog.f */
+incdir+include
source/simframe_pkg.sv
source/pattern_fifo.sv
source/simframe_regs.sv
source/frame_streamer.sv
source/simframe_ctl.sv
tb/simframe_ctl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pattern-frame controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module simframe_ctl_tb -f verilog.f \
   -o simframe_sim > sim.log 2>&1 \
   && ./obj_dir/simframe_sim >> sim.log 2>&1 \
   || echo "Regression failed" >> sim.log

if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then
   echo "FAIL, see sim.log"
   exit 1
fi
echo "PASS"
exit 0

/* include/simframe_tb_vectors.svh */
`ifndef SIMFRAME_TB_VECTORS_SVH
`define SIMFRAME_TB_VECTORS_SVH

// ========================================
// Testbench vector table
// ========================================

// Row operations
typedef enum logic [2:0] {
   OP_WRITE,   // write data to idx, expect resp
   OP_READ,    // read idx, expect exp and resp
   OP_READY,   // out_tready mode in data: 0 low, 1 high, 2 random
   OP_STREAM,  // data words of loop exp (1 = F0, 2 = F1)
   OP_SWITCH,  // finish current pass, then data words of loop exp
   OP_STOP,    // finish current pass, stream must stop
   OP_IDLE,    // data cycles with out_tvalid and new_job low
   OP_JOBS     // new_job high cycles so far equal exp
} op_t;

// Columns: op, idx, data, exp, resp
typedef struct packed {
   op_t        op;
   reg_index_t idx;
   reg_data_t  data;
   reg_data_t  exp;
   resp_t      resp;
} vec_t;

// Pattern loops in load order
localparam reg_data_t F0_W0 = 32'hc0de_0a01;
localparam reg_data_t F0_W1 = 32'h5eed_0b02;
localparam reg_data_t F0_W2 = 32'hfa11_0c03;
localparam reg_data_t F1_W0 = 32'h0dd5_1d04;
localparam reg_data_t F1_W1 = 32'hbeef_1e05;

localparam int NUM_VECS = 51;

localparam vec_t VECTORS [NUM_VECS] = '{
   // Reset values and decode errors
   '{OP_IDLE,   REG_MODULE_REV,     32'd8,        32'd0,    RESP_OKAY},
   '{OP_READ,   REG_MODULE_REV,     32'd0,        32'd1,    RESP_OKAY},
   '{OP_READ,   REG_CYCLES_PER_PKT, 32'd0,        32'd32,   RESP_OKAY},
   '{OP_READ,   REG_PKTS_PER_FRAME, 32'd0,        32'd2048, RESP_OKAY},
   '{OP_READ,   REG_START,          32'd0,        32'd0,    RESP_OKAY},
   '{OP_READ,   5'd9,               32'd0,        32'd0,    RESP_DECERR},
   '{OP_WRITE,  5'd9,               32'h1234,     32'd0,    RESP_DECERR},
   '{OP_JOBS,   REG_MODULE_REV,     32'd0,        32'd0,    RESP_OKAY},
   // Loading and geometry
   '{OP_WRITE,  REG_LOAD_F0,        F0_W0,        32'd0,    RESP_OKAY},
   '{OP_WRITE,  REG_LOAD_F0,        F0_W1,        32'd0,    RESP_OKAY},
   '{OP_WRITE,  REG_LOAD_F0,        F0_W2,        32'd0,    RESP_OKAY},
   '{OP_READ,   REG_LOAD_F0,        32'd0,        32'd3,    RESP_OKAY},
   '{OP_WRITE,  REG_LOAD_F1,        F1_W0,        32'd0,    RESP_OKAY},
   '{OP_WRITE,  REG_LOAD_F1,        F1_W1,        32'd0,    RESP_OKAY},
   '{OP_READ,   REG_LOAD_F1,        32'd0,        32'd2,    RESP_OKAY},
   '{OP_WRITE,  REG_CYCLES_PER_PKT, 32'd100,      32'd0,    RESP_OKAY},
   '{OP_READ,   REG_CYCLES_PER_PKT, 32'd0,        32'd100,  RESP_OKAY},
   '{OP_WRITE,  REG_PKTS_PER_FRAME, 32'd8,        32'd0,    RESP_OKAY},
   '{OP_READ,   REG_PKTS_PER_FRAME, 32'd0,        32'd8,    RESP_OKAY},
   '{OP_WRITE,  REG_CYCLES_PER_PKT, 32'd0,        32'd0,    RESP_OKAY},
   '{OP_READ,   REG_CYCLES_PER_PKT, 32'd0,        32'd100,  RESP_OKAY},
   // Streaming F0 with ready held high
   '{OP_READY,  REG_MODULE_REV,     32'd1,        32'd0,    RESP_OKAY},
   '{OP_WRITE,  REG_START,          32'd1,        32'd0,    RESP_OKAY},
   '{OP_STREAM, REG_MODULE_REV,     32'd9,        32'd1,    RESP_OKAY},
   '{OP_READ,   REG_START,          32'd0,        32'd1,    RESP_OKAY},
   '{OP_JOBS,   REG_MODULE_REV,     32'd0,        32'd1,    RESP_OKAY},
   // Back-pressure
   '{OP_READY,  REG_MODULE_REV,     32'd2,        32'd0,    RESP_OKAY},
   '{OP_STREAM, REG_MODULE_REV,     32'd12,       32'd1,    RESP_OKAY},
   // Active FIFO is locked
   '{OP_WRITE,  REG_LOAD_F0,        32'hbad0_0bad, 32'd0,   RESP_OKAY},
   '{OP_READ,   REG_LOAD_F0,        32'd0,        32'd3,    RESP_OKAY},
   '{OP_WRITE,  REG_FIFO_CTL,       32'd1,        32'd0,    RESP_OKAY},
   '{OP_READ,   REG_LOAD_F0,        32'd0,        32'd3,    RESP_OKAY},
   '{OP_WRITE,  REG_CYCLES_PER_PKT, 32'd200,      32'd0,    RESP_OKAY},
   '{OP_READ,   REG_CYCLES_PER_PKT, 32'd0,        32'd100,  RESP_OKAY},
   '{OP_WRITE,  REG_PKTS_PER_FRAME, 32'd50,       32'd0,    RESP_OKAY},
   '{OP_READ,   REG_PKTS_PER_FRAME, 32'd0,        32'd8,    RESP_OKAY},
   // Switch to F1 at the pass boundary
   '{OP_READY,  REG_MODULE_REV,     32'd0,        32'd0,    RESP_OKAY},
   '{OP_WRITE,  REG_START,          32'd2,        32'd0,    RESP_OKAY},
   '{OP_SWITCH, REG_MODULE_REV,     32'd4,        32'd2,    RESP_OKAY},
   '{OP_READ,   REG_START,          32'd0,        32'd2,    RESP_OKAY},
   '{OP_JOBS,   REG_MODULE_REV,     32'd0,        32'd1,    RESP_OKAY},
   // Stop, clear F1, start on an empty FIFO
   '{OP_READY,  REG_MODULE_REV,     32'd0,        32'd0,    RESP_OKAY},
   '{OP_WRITE,  REG_START,          32'd0,        32'd0,    RESP_OKAY},
   '{OP_STOP,   REG_MODULE_REV,     32'd0,        32'd0,    RESP_OKAY},
   '{OP_READ,   REG_START,          32'd0,        32'd0,    RESP_OKAY},
   '{OP_WRITE,  REG_FIFO_CTL,       32'd2,        32'd0,    RESP_OKAY},
   '{OP_READ,   REG_LOAD_F1,        32'd0,        32'd0,    RESP_OKAY},
   '{OP_WRITE,  REG_START,          32'd2,        32'd0,    RESP_OKAY},
   '{OP_IDLE,   REG_MODULE_REV,     32'd20,       32'd0,    RESP_OKAY},
   '{OP_JOBS,   REG_MODULE_REV,     32'd0,        32'd1,    RESP_OKAY},
   '{OP_READ,   REG_START,          32'd0,        32'd0,    RESP_OKAY}
};

`endif

/* tb/simframe_ctl_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module simframe_ctl_tb import simframe_pkg::*; ();

`include "simframe_tb_vectors.svh"

   localparam int TIMEOUT = 200;

   logic       clk;
   logic       resetn;
   logic       reg_write;
   logic       reg_read;
   reg_index_t reg_addr;
   reg_data_t  reg_wdata;
   logic       reg_wdone;
   resp_t      reg_wresp;
   logic       reg_rvalid;
   reg_data_t  reg_rdata;
   resp_t      reg_rresp;
   logic [31:0] out_tdata;
   logic       out_tvalid;
   logic       out_tready;
   geom_t      cycles_per_pkt;
   geom_t      pkts_per_frame;
   logic       new_job;

   // Monitor state
   reg_data_t  rx_q [$];
   int         job_cnt;
   // Checker state, loop ids 1 = F0 and 2 = F1
   int         loop_pos [3];
   int         stream_sel;
   int         ready_mode;
   logic [31:0] rnd;
   vec_t       row;

   simframe_ctl #(
      .PATTERN_WIDTH (32),
      .FIFO_DEPTH    (16)
   ) UUT (
      .clk            (clk),
      .resetn         (resetn),
      .reg_write      (reg_write),
      .reg_read       (reg_read),
      .reg_addr       (reg_addr),
      .reg_wdata      (reg_wdata),
      .reg_wdone      (reg_wdone),
      .reg_wresp      (reg_wresp),
      .reg_rvalid     (reg_rvalid),
      .reg_rdata      (reg_rdata),
      .reg_rresp      (reg_rresp),
      .out_tdata      (out_tdata),
      .out_tvalid     (out_tvalid),
      .out_tready     (out_tready),
      .cycles_per_pkt (cycles_per_pkt),
      .pkts_per_frame (pkts_per_frame),
      .new_job        (new_job)
   );

   // ========================================
   // Clock, ready driver and monitor
   // ========================================
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Ready changes 1 ns after the edge
   initial begin
      rnd = $urandom(32'ha0ce_3bbb);
      forever begin
         @(posedge clk);
         #1;
         rnd = $urandom;
         if (ready_mode == 0)
            out_tready = 1'b0;
         else if (ready_mode == 1)
            out_tready = 1'b1;
         else
            out_tready = rnd[0];
      end
   end

   // Sampled mid-cycle, a transfer follows at the next rising edge
   always @(negedge clk) begin
      if (out_tvalid && out_tready)
         rx_q.push_back(out_tdata);
      if (new_job)
         job_cnt++;
   end

   // ========================================
   // Error reporting
   // ========================================
   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input reg_data_t got, input reg_data_t exp);
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
   endtask

   task automatic report_problem(input string what);
      $display("%s", what);
      abort_run();
   endtask

   // ========================================
   // Register access
   // ========================================
   task automatic write_reg(input reg_index_t idx, input reg_data_t data, input resp_t resp);
      int waited;
      waited = 0;
      @(posedge clk);
      #1;
      reg_write = 1'b1;
      reg_addr  = idx;
      reg_wdata = data;
      @(posedge clk);
      #1;
      reg_write = 1'b0;
      @(negedge clk);
      while (!reg_wdone && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      assert (reg_wdone) else report_problem("timeout waiting for reg_wdone");
      assert (reg_wresp == resp)
         else report_mismatch("reg_wresp", reg_data_t'(reg_wresp), reg_data_t'(resp));
   endtask

   task automatic read_reg(input reg_index_t idx, input reg_data_t exp, input resp_t resp);
      int waited;
      waited = 0;
      @(posedge clk);
      #1;
      reg_read = 1'b1;
      reg_addr = idx;
      @(posedge clk);
      #1;
      reg_read = 1'b0;
      @(negedge clk);
      while (!reg_rvalid && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      assert (reg_rvalid) else report_problem("timeout waiting for reg_rvalid");
      assert (reg_rresp == resp)
         else report_mismatch("reg_rresp", reg_data_t'(reg_rresp), reg_data_t'(resp));
      // Data only matters on an OKAY read
      if (resp == RESP_OKAY) begin
         assert (reg_rdata == exp) else report_mismatch("reg_rdata", reg_rdata, exp);
      end
      // Geometry output ports carry the same values
      if (idx == REG_CYCLES_PER_PKT) begin
         assert (cycles_per_pkt == geom_t'(exp))
            else report_mismatch("cycles_per_pkt", reg_data_t'(cycles_per_pkt), exp);
      end
      if (idx == REG_PKTS_PER_FRAME) begin
         assert (pkts_per_frame == geom_t'(exp))
            else report_mismatch("pkts_per_frame", reg_data_t'(pkts_per_frame), exp);
      end
   endtask

   // ========================================
   // Stream checks
   // ========================================
   function automatic int loop_len(input int sel);
      return (sel == 1) ? 3 : 2;
   endfunction

   // Expected word of a loop, in load order
   function automatic reg_data_t loop_word(input int sel, input int pos);
      if (sel == 1)
         return (pos == 0) ? F0_W0 : (pos == 1) ? F0_W1 : F0_W2;
      return (pos == 0) ? F1_W0 : F1_W1;
   endfunction

   task automatic take_word(input int sel);
      int waited;
      reg_data_t got;
      reg_data_t want;
      waited = 0;
      while (rx_q.size() == 0 && waited < TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      assert (rx_q.size() != 0) else report_problem("timeout waiting for a stream word");
      got  = rx_q.pop_front();
      want = loop_word(sel, loop_pos[sel]);
      assert (got == want) else report_mismatch("out_tdata", got, want);
      loop_pos[sel] = (loop_pos[sel] + 1) % loop_len(sel);
   endtask

   task automatic check_stream(input int count, input int sel);
      stream_sel = sel;
      repeat (count) take_word(sel);
   endtask

   // Ready is low here, so the pass in progress is fixed by what arrived
   task automatic switch_loop(input int count, input int new_sel);
      int owed;
      while (rx_q.size() != 0)
         take_word(stream_sel);
      owed = loop_len(stream_sel) - loop_pos[stream_sel];
      ready_mode = 2;
      repeat (owed) take_word(stream_sel);
      // New loop starts at its first word
      loop_pos[new_sel] = 0;
      stream_sel = new_sel;
      repeat (count) take_word(new_sel);
   endtask

   task automatic stop_stream();
      int owed;
      while (rx_q.size() != 0)
         take_word(stream_sel);
      owed = loop_len(stream_sel) - loop_pos[stream_sel];
      ready_mode = 1;
      repeat (owed) take_word(stream_sel);
      repeat (4) @(negedge clk);
      assert (!out_tvalid) else report_problem("out_tvalid still high after the last pass");
      assert (rx_q.size() == 0) else report_problem("stream word seen after the last pass");
   endtask

   task automatic expect_idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         assert (!out_tvalid) else report_problem("out_tvalid high while idle");
         assert (!new_job) else report_problem("new_job pulsed while idle");
      end
   endtask

   // ========================================
   // Main sequence
   // ========================================
   initial begin
      resetn     = 1'b0;
      reg_write  = 1'b0;
      reg_read   = 1'b0;
      reg_addr   = '0;
      reg_wdata  = '0;
      out_tready = 1'b0;
      ready_mode = 0;
      job_cnt    = 0;
      stream_sel = 1;
      loop_pos   = '{0, 0, 0};

      repeat (5) @(posedge clk);
      #1;
      resetn = 1'b1;

      for (int i = 0; i < NUM_VECS; i++) begin
         row = VECTORS[i];
         case (row.op)
            OP_WRITE:  write_reg(row.idx, row.data, row.resp);
            OP_READ:   read_reg(row.idx, row.exp, row.resp);
            OP_READY:  ready_mode = int'(row.data);
            OP_STREAM: check_stream(int'(row.data), int'(row.exp));
            OP_SWITCH: switch_loop(int'(row.data), int'(row.exp));
            OP_STOP:   stop_stream();
            OP_IDLE:   expect_idle(int'(row.data));
            OP_JOBS:
               assert (job_cnt == int'(row.exp))
                  else report_mismatch("new_job cycles", reg_data_t'(job_cnt), row.exp);
            default:   report_problem("unknown operation in vector table");
         endcase
      end

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

/* source/simframe_ctl.sv */
`timescale 1ns/10ps
`default_nettype none

// ========================================
// Pattern-frame controller top level
// ========================================
module simframe_ctl import simframe_pkg::*; #(
   parameter int PATTERN_WIDTH = 32,
   parameter int FIFO_DEPTH    = 16
) (
   input  wire                      clk,
   input  wire                      resetn,

   // Register port
   input  wire                      reg_write,
   input  wire                      reg_read,
   input  reg_index_t               reg_addr,
   input  reg_data_t                reg_wdata,
   output logic                     reg_wdone,
   output resp_t                    reg_wresp,
   output logic                     reg_rvalid,
   output reg_data_t                reg_rdata,
   output resp_t                    reg_rresp,

   // Output stream
   output logic [PATTERN_WIDTH-1:0] out_tdata,
   output logic                     out_tvalid,
   input  wire                      out_tready,

   // Frame geometry and job strobe
   output geom_t                    cycles_per_pkt,
   output geom_t                    pkts_per_frame,
   output logic                     new_job
);

   reg_data_t                load_data;
   logic [PATTERN_WIDTH-1:0] fifo_load_data;
   logic                     load_f0;
   logic                     load_f1;
   logic                     clear_f0;
   logic                     clear_f1;
   logic                     pop_f0;
   logic                     pop_f1;
   count_t                   f0_count;
   count_t                   f1_count;
   logic [PATTERN_WIDTH-1:0] f0_data;
   logic [PATTERN_WIDTH-1:0] f1_data;
   fifo_sel_t                fifo_on_deck;
   fifo_sel_t                active_fifo;

   // Register word sized to the pattern width
   assign fifo_load_data = PATTERN_WIDTH'(load_data);

   // ========================================
   // Register block
   // ========================================
   simframe_regs regs (
      .clk            (clk),
      .resetn         (resetn),
      .reg_write      (reg_write),
      .reg_read       (reg_read),
      .reg_addr       (reg_addr),
      .reg_wdata      (reg_wdata),
      .reg_wdone      (reg_wdone),
      .reg_wresp      (reg_wresp),
      .reg_rvalid     (reg_rvalid),
      .reg_rdata      (reg_rdata),
      .reg_rresp      (reg_rresp),
      .f0_count       (f0_count),
      .f1_count       (f1_count),
      .active_fifo    (active_fifo),
      .load_data      (load_data),
      .load_f0        (load_f0),
      .load_f1        (load_f1),
      .clear_f0       (clear_f0),
      .clear_f1       (clear_f1),
      .fifo_on_deck   (fifo_on_deck),
      .cycles_per_pkt (cycles_per_pkt),
      .pkts_per_frame (pkts_per_frame),
      .new_job        (new_job)
   );

   // ========================================
   // Pattern FIFOs
   // ========================================
   pattern_fifo #(
      .PATTERN_WIDTH (PATTERN_WIDTH),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) fifo_0 (
      .clk       (clk),
      .resetn    (resetn),
      .load      (load_f0),
      .load_data (fifo_load_data),
      .clear     (clear_f0),
      .pop       (pop_f0),
      .head_data (f0_data),
      .count     (f0_count)
   );

   pattern_fifo #(
      .PATTERN_WIDTH (PATTERN_WIDTH),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) fifo_1 (
      .clk       (clk),
      .resetn    (resetn),
      .load      (load_f1),
      .load_data (fifo_load_data),
      .clear     (clear_f1),
      .pop       (pop_f1),
      .head_data (f1_data),
      .count     (f1_count)
   );

   // ========================================
   // Output streamer
   // ========================================
   frame_streamer #(
      .PATTERN_WIDTH (PATTERN_WIDTH)
   ) streamer (
      .clk          (clk),
      .resetn       (resetn),
      .fifo_on_deck (fifo_on_deck),
      .f0_count     (f0_count),
      .f1_count     (f1_count),
      .f0_data      (f0_data),
      .f1_data      (f1_data),
      .out_tready   (out_tready),
      .out_tdata    (out_tdata),
      .out_tvalid   (out_tvalid),
      .active_fifo  (active_fifo),
      .pop_f0       (pop_f0),
      .pop_f1       (pop_f1)
   );

endmodule

`default_nettype wire

/* source/frame_streamer.sv */
`timescale 1ns/10ps
`default_nettype none

// ========================================
// Output state machine, passes over the active FIFO
// ========================================
module frame_streamer import simframe_pkg::*; #(
   parameter int PATTERN_WIDTH = 32
) (
   input  wire                      clk,
   input  wire                      resetn,
   input  fifo_sel_t                fifo_on_deck,
   input  count_t                   f0_count,
   input  count_t                   f1_count,
   input  wire [PATTERN_WIDTH-1:0]  f0_data,
   input  wire [PATTERN_WIDTH-1:0]  f1_data,
   input  wire                      out_tready,
   output logic [PATTERN_WIDTH-1:0] out_tdata,
   output logic                     out_tvalid,
   output fifo_sel_t                active_fifo,
   output logic                     pop_f0,
   output logic                     pop_f1
);

   // Idle word is the fill byte repeated, trimmed to width
   localparam int FILL_BYTES = (PATTERN_WIDTH + 7) / 8;
   localparam logic [FILL_BYTES*8-1:0] FILL_WIDE = {FILL_BYTES{IDLE_FILL}};
   localparam logic [PATTERN_WIDTH-1:0] IDLE_WORD = FILL_WIDE[PATTERN_WIDTH-1:0];

   typedef enum logic {
      OSM_INIT,
      OSM_RUN
   } osm_state_t;

   osm_state_t osm_state;
   // Transfers left in the current pass
   count_t     pass_cnt;
   logic       xfer;

   assign xfer = out_tvalid && out_tready;

   // Data follows the active FIFO's head
   always_comb begin
      case (active_fifo)
         SEL_F0:  out_tdata = f0_data;
         SEL_F1:  out_tdata = f1_data;
         default: out_tdata = IDLE_WORD;
      endcase
   end

   // Every transfer recirculates the head word
   assign pop_f0 = xfer && (active_fifo == SEL_F0);
   assign pop_f1 = xfer && (active_fifo == SEL_F1);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         osm_state   <= OSM_INIT;
         active_fifo <= SEL_NONE;
         out_tvalid  <= 1'b0;
         pass_cnt    <= '0;
      end else begin
         case (osm_state)
            OSM_INIT: begin
               out_tvalid <= 1'b0;
               osm_state  <= OSM_RUN;
            end
            OSM_RUN: begin
               // Idle, or a word just went out
               if (!out_tvalid || xfer) begin
                  pass_cnt <= pass_cnt - 1'b1;

                  // Pass boundary, sample on-deck
                  if (!out_tvalid || pass_cnt == count_t'(1)) begin
                     if (fifo_on_deck == SEL_F0 && f0_count != '0) begin
                        active_fifo <= SEL_F0;
                        pass_cnt    <= f0_count;
                        out_tvalid  <= 1'b1;
                     end else if (fifo_on_deck == SEL_F1 && f1_count != '0) begin
                        active_fifo <= SEL_F1;
                        pass_cnt    <= f1_count;
                        out_tvalid  <= 1'b1;
                     end else begin
                        // Nothing on deck, drop back to idle
                        active_fifo <= SEL_NONE;
                        out_tvalid  <= 1'b0;
                     end
                  end
               end
            end
            default: osm_state <= OSM_INIT;
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/simframe_regs.sv */
`timescale 1ns/10ps
`default_nettype none

// ========================================
// Register decode, geometry and on-deck selection
// ========================================
module simframe_regs import simframe_pkg::*; (
   input  wire        clk,
   input  wire        resetn,

   // Register strobe port
   input  wire        reg_write,
   input  wire        reg_read,
   input  reg_index_t reg_addr,
   input  reg_data_t  reg_wdata,
   output logic       reg_wdone,
   output resp_t      reg_wresp,
   output logic       reg_rvalid,
   output reg_data_t  reg_rdata,
   output resp_t      reg_rresp,

   // FIFO status and streamer state
   input  count_t     f0_count,
   input  count_t     f1_count,
   input  fifo_sel_t  active_fifo,

   // FIFO load and clear pulses
   output reg_data_t  load_data,
   output logic       load_f0,
   output logic       load_f1,
   output logic       clear_f0,
   output logic       clear_f1,

   // Control outputs
   output fifo_sel_t  fifo_on_deck,
   output geom_t      cycles_per_pkt,
   output geom_t      pkts_per_frame,
   output logic       new_job
);

   logic addr_known;
   logic start_f0;
   logic start_f1;
   logic geom_ok;

   // Indices past the last register decode as errors
   assign addr_known = (reg_addr <= REG_PKTS_PER_FRAME);

   // START values that name a FIFO holding data
   assign start_f0 = (reg_wdata == 32'd1) && (f0_count != '0);
   assign start_f1 = (reg_wdata == 32'd2) && (f1_count != '0);

   // Geometry is frozen while streaming and never set to zero
   assign geom_ok = (reg_wdata[15:0] != '0) && (active_fifo == SEL_NONE);

   // ========================================
   // FIFO pulses, acted on at this same edge
   // ========================================
   assign load_data = reg_wdata;

   // The active FIFO is locked against loads
   assign load_f0 = reg_write && (reg_addr == REG_LOAD_F0) && (active_fifo != SEL_F0);
   assign load_f1 = reg_write && (reg_addr == REG_LOAD_F1) && (active_fifo != SEL_F1);

   // And against clears
   assign clear_f0 = reg_write && (reg_addr == REG_FIFO_CTL)
                   && reg_wdata[BIT_F0_CLEAR] && (active_fifo != SEL_F0);
   assign clear_f1 = reg_write && (reg_addr == REG_FIFO_CTL)
                   && reg_wdata[BIT_F1_CLEAR] && (active_fifo != SEL_F1);

   // ========================================
   // Write side
   // ========================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         reg_wdone      <= 1'b0;
         new_job        <= 1'b0;
         fifo_on_deck   <= SEL_NONE;
         cycles_per_pkt <= DEFAULT_CYCLES_PER_PKT;
         pkts_per_frame <= DEFAULT_PKTS_PER_FRAME;
      end else begin
         // Single-cycle strobes
         reg_wdone <= reg_write;
         new_job   <= 1'b0;

         if (reg_write) begin
            case (reg_addr)
               REG_START: begin
                  if (reg_wdata == '0)
                     fifo_on_deck <= SEL_NONE;
                  else if (start_f0)
                     fifo_on_deck <= SEL_F0;
                  else if (start_f1)
                     fifo_on_deck <= SEL_F1;

                  // A job is new only when the streamer is idle
                  new_job <= (start_f0 || start_f1) && (active_fifo == SEL_NONE);
               end
               REG_CYCLES_PER_PKT:
                  if (geom_ok) cycles_per_pkt <= reg_wdata[15:0];
               REG_PKTS_PER_FRAME:
                  if (geom_ok) pkts_per_frame <= reg_wdata[15:0];
               // FIFO_CTL and loads act through the pulses above
               default: ;
            endcase
         end
      end
   end

   // Write response, valid with reg_wdone
   always_ff @(posedge clk) begin
      if (reg_write)
         reg_wresp <= addr_known ? RESP_OKAY : RESP_DECERR;
   end

   // ========================================
   // Read side
   // ========================================
   always_ff @(posedge clk) begin
      if (!resetn)
         reg_rvalid <= 1'b0;
      else
         reg_rvalid <= reg_read;
   end

   // Read data and response, valid with reg_rvalid
   always_ff @(posedge clk) begin
      if (reg_read) begin
         reg_rresp <= RESP_OKAY;
         case (reg_addr)
            REG_MODULE_REV:     reg_rdata <= MODULE_VERSION;
            REG_FIFO_CTL:       reg_rdata <= '0;
            REG_LOAD_F0:        reg_rdata <= reg_data_t'(f0_count);
            REG_LOAD_F1:        reg_rdata <= reg_data_t'(f1_count);
            REG_START:          reg_rdata <= reg_data_t'(active_fifo);
            REG_CYCLES_PER_PKT: reg_rdata <= reg_data_t'(cycles_per_pkt);
            REG_PKTS_PER_FRAME: reg_rdata <= reg_data_t'(pkts_per_frame);
            default: begin
               reg_rdata <= '0;
               reg_rresp <= RESP_DECERR;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/pattern_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

// ========================================
// Ring-buffer FIFO holding one pattern loop
// ========================================
module pattern_fifo import simframe_pkg::*; #(
   parameter int PATTERN_WIDTH = 32,
   parameter int FIFO_DEPTH    = 16
) (
   input  wire                     clk,
   input  wire                     resetn,
   input  wire                     load,
   input  wire [PATTERN_WIDTH-1:0] load_data,
   input  wire                     clear,
   input  wire                     pop,
   output logic [PATTERN_WIDTH-1:0] head_data,
   output count_t                  count
);

   // Pointer width, at least one bit
   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

   typedef logic [PTR_W-1:0] ptr_t;

   // Pattern storage
   logic [PATTERN_WIDTH-1:0] mem [FIFO_DEPTH];

   ptr_t rd_ptr;
   ptr_t wr_ptr;

   logic full;
   logic not_empty;
   logic do_load;
   logic do_pop;

   // Advance with wrap at the end of the ring
   function automatic ptr_t next_ptr(input ptr_t p);
      if (p == ptr_t'(FIFO_DEPTH - 1))
         return '0;
      return p + 1'b1;
   endfunction

   assign full      = (count == count_t'(FIFO_DEPTH));
   assign not_empty = (count != '0);

   // Loads beyond capacity are dropped
   assign do_load = load && !full;
   // A pop on an empty ring has no word to recirculate
   assign do_pop  = pop && not_empty;

   // Head word is always visible
   assign head_data = mem[rd_ptr];

   // Storage write: head copied to tail on a pop, new word on a load
   always_ff @(posedge clk) begin
      if (do_pop)
         mem[wr_ptr] <= mem[rd_ptr];
      else if (do_load)
         mem[wr_ptr] <= load_data;
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (!resetn || clear) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else if (do_pop) begin
         // Word moves from head to tail, count stays put
         rd_ptr <= next_ptr(rd_ptr);
         wr_ptr <= next_ptr(wr_ptr);
      end else if (do_load) begin
         wr_ptr <= next_ptr(wr_ptr);
         count  <= count + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* source/simframe_pkg.sv */
`default_nettype none

// ========================================
// Shared definitions for the pattern-frame controller
// ========================================
package simframe_pkg;

   // Register map revision, bump on any map change
   localparam logic [31:0] MODULE_VERSION = 32'd1;

   // Word index into a 32-register window
   typedef logic [4:0]  reg_index_t;
   typedef logic [31:0] reg_data_t;

   // Register map
   localparam reg_index_t REG_MODULE_REV     = 5'd0;
   localparam reg_index_t REG_FIFO_CTL       = 5'd1;
   localparam reg_index_t REG_LOAD_F0        = 5'd2;
   localparam reg_index_t REG_LOAD_F1        = 5'd3;
   localparam reg_index_t REG_START          = 5'd4;
   localparam reg_index_t REG_CYCLES_PER_PKT = 5'd5;
   localparam reg_index_t REG_PKTS_PER_FRAME = 5'd6;

   // Bits within FIFO_CTL
   localparam int BIT_F0_CLEAR = 0;
   localparam int BIT_F1_CLEAR = 1;

   // Bus response codes
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_DECERR = 2'd3
   } resp_t;

   // FIFO occupancy, limits depth to 16384
   typedef logic [14:0] count_t;

   // Frame geometry field and its reset values
   typedef logic [15:0] geom_t;
   localparam geom_t DEFAULT_CYCLES_PER_PKT = 16'd32;
   localparam geom_t DEFAULT_PKTS_PER_FRAME = 16'd2048;

   // FIFO selection, on-deck and active
   typedef enum logic [1:0] {
      SEL_NONE = 2'd0,
      SEL_F0   = 2'd1,
      SEL_F1   = 2'd2
   } fifo_sel_t;

   // Output byte while no FIFO streams
   localparam logic [7:0] IDLE_FILL = 8'h55;

endpackage

`default_nettype wire
